//--- hw/cramSeq_macros.svh
// Shared widths, stack depth and diagnostic register offsets, included by every design file
`ifndef CRAMSEQ_MACROS_SVH
`define CRAMSEQ_MACROS_SVH

// Control-store address width gives 256 microwords
`define CRA_W 8

// Subroutine return stack
`define STACK_DEPTH 8
`define SP_W 3

// Diagnostic Wishbone register offsets
`define REG_CADR  3'd0
`define REG_CDATA 3'd1
`define REG_CTRL  3'd2
`define REG_DIAG  3'd3
`define REG_STAT  3'd4

// Wishbone data bus width
`define WB_DW 32

`endif

//--- hw/cramPkg.sv
// Types shared by the sequencer blocks and the testbench, referenced as cramPkg::name
`include "cramSeq_macros.svh"

package cramPkg;

  // One control-store address
  typedef logic [`CRA_W-1:0] tCradr;

  // Dispatch opcodes, each source is ORed into the jump field
  typedef enum logic [2:0] {
    DISP_NONE = 3'd0,
    DISP_DRJ  = 3'd1,
    DISP_SKIP = 3'd2,
    DISP_DIAG = 3'd3,
    DISP_RET  = 3'd4
  } tDispOp;

  // Microword layout, 24 bits with j in the top byte
  typedef struct packed {
    tCradr      j;
    tDispOp     disp;
    logic       call;
    logic [2:0] condSel;
    logic       halt;
    logic [7:0] field;
  } tMicroword;

  typedef enum logic [1:0] {
    RS_HALT = 2'd0,
    RS_RUN  = 2'd1,
    RS_STEP = 2'd2
  } tRunState;

  // Diagnostic register select
  typedef enum logic [2:0] {
    R_CADR  = `REG_CADR,
    R_CDATA = `REG_CDATA,
    R_CTRL  = `REG_CTRL,
    R_DIAG  = `REG_DIAG,
    R_STAT  = `REG_STAT
  } tRegSel;

  // Status word as read from REG_STAT, stackErr lands in bit 0
  typedef struct packed {
    tCradr           cradr;
    logic [`SP_W-1:0] sp;
    logic            running;
    logic            stackErr;
  } tStatus;

endpackage

//--- hw/stackPort.sv
// Connection between the sequencer control and the return stack, one instance in the top level
`timescale 1ns/1ps
`include "cramSeq_macros.svh"

interface stackPort;

  // Requests from the sequencer, never both high in one cycle
  logic           push;
  logic           pop;
  cramPkg::tCradr pushAdr;

  // Top of stack, shown combinationally
  cramPkg::tCradr retAdr;
  // Pointer to the next empty entry
  logic [`SP_W-1:0] sp;
  // Sticky error, also high in the cycle of a refused request
  logic           err;

  modport ctrl (
    output push, pop, pushAdr,
    input  err
  );

  modport stack (
    input  push, pop, pushAdr,
    output retAdr, sp, err
  );

endinterface

//--- hw/controlStore.sv
// Microword memory, loaded through the diagnostic port and read by the sequencer address
`timescale 1ns/1ps
`include "cramSeq_macros.svh"

module controlStore (
  input  logic               clk,
  input  logic               wrEn,
  input  cramPkg::tCradr     wrAdr,
  input  cramPkg::tMicroword wrData,
  input  cramPkg::tCradr     rdAdr,
  output cramPkg::tMicroword uword
);

  localparam int Words = 2 ** `CRA_W;

  //////////////////////////////////////////////////////////////////////
  // Storage array
  //////////////////////////////////////////////////////////////////////

  // One microword per control-store address
  cramPkg::tMicroword mem [Words];

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  // Diagnostic loads only, the diagnostic port blocks them while running
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAdr] <= wrData;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Asynchronous read
  // The word at the current address is decoded in the same cycle
  assign uword = mem[rdAdr];

endmodule

//--- hw/dispatchSelect.sv
// Dispatch multiplexer: picks the bits ORed into the jump field by the dispatch opcode
`timescale 1ns/1ps

module dispatchSelect (
  input  cramPkg::tDispOp disp,
  input  logic [2:0]      condSel,
  input  logic [7:0]      cond,
  input  logic [3:0]      drj,
  input  cramPkg::tCradr  diagAdr,
  input  cramPkg::tCradr  retAdr,
  output cramPkg::tCradr  dispBits
);

  // Selected skip condition
  logic skipBit;

  //////////////////////////////////////////////////////////////////////
  // Skip condition select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (condSel)
      3'd0:    skipBit = cond[0];
      3'd1:    skipBit = cond[1];
      3'd2:    skipBit = cond[2];
      3'd3:    skipBit = cond[3];
      3'd4:    skipBit = cond[4];
      3'd5:    skipBit = cond[5];
      3'd6:    skipBit = cond[6];
      default: skipBit = cond[7];
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Dispatch source by opcode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dispBits = '0;
    case (disp)
      cramPkg::DISP_NONE: begin
        // Plain jump
        dispBits = '0;
      end
      cramPkg::DISP_DRJ: begin
        // External nibble in the low four bits
        dispBits[3:0] = drj;
      end
      cramPkg::DISP_SKIP: begin
        // Two-way branch on bit 0
        dispBits[0] = skipBit;
      end
      cramPkg::DISP_DIAG: begin
        dispBits = diagAdr;
      end
      cramPkg::DISP_RET: begin
        // Popped return address, J is normally 0 here
        dispBits = retAdr;
      end
      default: begin
        dispBits = '0;
      end
    endcase
  end

endmodule

//--- hw/returnStack.sv
// Subroutine return stack for the sequencer, with sticky overflow and underflow error
`timescale 1ns/1ps
`include "cramSeq_macros.svh"

module returnStack (
  input  logic    clk,
  input  logic    RESET,
  input  logic    clearErr,
  stackPort.stack stk
);

  cramPkg::tCradr   entries [`STACK_DEPTH];
  logic [`SP_W-1:0] sp;
  // Set with all entries in use, sp has wrapped to 0 then
  logic             full;
  logic             errFlag;
  logic             empty;
  logic             pushOk;
  logic             popOk;
  logic             fault;

  assign empty  = (sp == '0) && !full;
  // Nothing moves while the error stands
  assign pushOk = stk.push && !full && !errFlag;
  assign popOk  = stk.pop && !empty && !errFlag;
  assign fault  = (stk.push && full) || (stk.pop && empty);

  assign stk.sp     = sp;
  // Top entry sits just below the pointer
  assign stk.retAdr = entries[sp - 1'b1];
  // Current refusal shows at once so the sequencer holds its address
  assign stk.err    = errFlag || fault;

  always_ff @(posedge clk) begin
    if (RESET) begin
      sp      <= '0;
      full    <= 1'b0;
      errFlag <= 1'b0;
    end else begin
      if (pushOk) begin
        sp   <= sp + 1'b1;
        full <= (sp == `SP_W'(`STACK_DEPTH - 1));
      end else if (popOk) begin
        sp   <= sp - 1'b1;
        full <= 1'b0;
      end
      // Error wins over a clear in the same cycle
      if (fault) begin
        errFlag <= 1'b1;
      end else if (clearErr) begin
        errFlag <= 1'b0;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (pushOk) begin
      entries[sp] <= stk.pushAdr;
    end
  end

endmodule

//--- hw/seqControl.sv
// Sequencer control: holds the microaddress and run state and drives stack push and pop
`timescale 1ns/1ps

module seqControl (
  input  logic               clk,
  input  logic               RESET,
  input  logic               run,
  input  logic               step,
  input  logic               clearPc,
  input  cramPkg::tMicroword uword,
  input  cramPkg::tCradr     dispBits,
  stackPort.ctrl             stk,
  output cramPkg::tCradr     cradr,
  output logic               running,
  output cramPkg::tDispOp    disp,
  output logic [2:0]         condSel
);

  cramPkg::tRunState runState;
  // Previous run level, a new run only starts on its rising edge
  logic runQ;
  logic runStart;
  // The microword at cradr is executed at the coming edge
  logic exec;

  assign runStart = run && !runQ;
  // A clear takes the edge, nothing executes then
  assign exec     = (runState != cramPkg::RS_HALT) && !clearPc;
  assign running  = (runState != cramPkg::RS_HALT);

  // Dispatch opcode and skip select go straight to the mux
  assign disp    = uword.disp;
  assign condSel = uword.condSel;

  //////////////////////////////////////////////////////////////////////
  // Stack requests
  //////////////////////////////////////////////////////////////////////

  // Call wins if a word carries both call and return
  assign stk.push    = exec && uword.call;
  assign stk.pop     = exec && (uword.disp == cramPkg::DISP_RET) && !uword.call;
  // Return address is the word after the caller
  assign stk.pushAdr = cradr + 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Microaddress register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (RESET) begin
      cradr <= '0;
    end else if (clearPc) begin
      cradr <= '0;
    end else if (exec && !stk.err) begin
      // Next address from the word at the old address
      cradr <= uword.j | dispBits;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run state FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (RESET) begin
      runState <= cramPkg::RS_HALT;
      runQ     <= 1'b0;
    end else begin
      runQ <= run;
      case (runState)
        cramPkg::RS_HALT: begin
          if (step) begin
            runState <= cramPkg::RS_STEP;
          end else if (runStart) begin
            runState <= cramPkg::RS_RUN;
          end
        end
        cramPkg::RS_RUN: begin
          // Halt word executes first, then stop
          if (exec && (stk.err || uword.halt)) begin
            runState <= cramPkg::RS_HALT;
          end else if (!run) begin
            runState <= cramPkg::RS_HALT;
          end
        end
        cramPkg::RS_STEP: begin
          // One word only, held over a clear
          if (exec) begin
            runState <= cramPkg::RS_HALT;
          end
        end
        default: runState <= cramPkg::RS_HALT;
      endcase
    end
  end

endmodule

//--- hw/diagPort.sv
// Diagnostic Wishbone classic slave: store loading, sequencer control and status readback
`timescale 1ns/1ps
`include "cramSeq_macros.svh"

module diagPort (
  input  logic                clk,
  input  logic                RESET,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [2:0]          adr,
  input  logic [`WB_DW-1:0]   datW,
  output logic [`WB_DW-1:0]   datR,
  output logic                ack,
  input  logic                running,
  input  cramPkg::tCradr      cradr,
  input  logic [`SP_W-1:0]    sp,
  input  logic                stackErr,
  output logic                wrEn,
  output cramPkg::tCradr      wrAdr,
  output cramPkg::tMicroword  wrData,
  output logic                run,
  output logic                step,
  output logic                clearPc,
  output logic                clearErr,
  output cramPkg::tCradr      diagAdr
);

  cramPkg::tRegSel regSel;
  cramPkg::tStatus status;
  // Store load address, advances on every accepted data write
  cramPkg::tCradr  cadrReg;
  // Transfer accepted at the coming edge, ack follows one cycle later
  logic            access;
  logic            wrAccess;

  assign regSel   = cramPkg::tRegSel'(adr);
  assign access   = cyc && stb && !ack;
  assign wrAccess = access && we;

  // Store write port
  assign wrEn   = wrAccess && (regSel == cramPkg::R_CDATA) && !running;
  assign wrAdr  = cadrReg;
  assign wrData = cramPkg::tMicroword'(datW[$bits(cramPkg::tMicroword)-1:0]);

  assign status.cradr    = cradr;
  assign status.sp       = sp;
  assign status.running  = running;
  assign status.stackErr = stackErr;

  //////////////////////////////////////////////////////////////////////
  // Handshake and registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (RESET) begin
      ack      <= 1'b0;
      cadrReg  <= '0;
      diagAdr  <= '0;
      run      <= 1'b0;
      step     <= 1'b0;
      clearPc  <= 1'b0;
      clearErr <= 1'b0;
    end else begin
      // Single-cycle ack
      ack      <= access;
      // Control pulses last one cycle
      step     <= 1'b0;
      clearPc  <= 1'b0;
      clearErr <= 1'b0;
      if (wrAccess && (regSel == cramPkg::R_CADR)) begin
        cadrReg <= datW[`CRA_W-1:0];
      end else if (wrEn) begin
        cadrReg <= cadrReg + 1'b1;
      end
      if (wrAccess && (regSel == cramPkg::R_CTRL)) begin
        run      <= datW[0];
        step     <= datW[1];
        clearPc  <= datW[2];
        clearErr <= datW[3];
      end
      if (wrAccess && (regSel == cramPkg::R_DIAG)) begin
        diagAdr <= datW[`CRA_W-1:0];
      end
    end
  end

  // Read data, valid with ack
  always_ff @(posedge clk) begin
    if (access) begin
      case (regSel)
        cramPkg::R_CADR: datR <= `WB_DW'(cadrReg);
        cramPkg::R_CTRL: datR <= `WB_DW'(run);
        cramPkg::R_DIAG: datR <= `WB_DW'(diagAdr);
        cramPkg::R_STAT: datR <= `WB_DW'(status);
        // Store data is write only
        default:         datR <= '0;
      endcase
    end
  end

endmodule

//--- hw/cramSeq.sv
// Top level of the microprogram sequencer, connects the blocks to plain ports
`timescale 1ns/1ps
`include "cramSeq_macros.svh"

module cramSeq (
  input  logic              clk,
  input  logic              RESET,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic [2:0]        adr,
  input  logic [`WB_DW-1:0] datW,
  output logic [`WB_DW-1:0] datR,
  output logic              ack,
  input  logic [7:0]        cond,
  input  logic [3:0]        drj,
  output cramPkg::tCradr    cradr,
  output logic [7:0]        field,
  output logic              running
);

  cramPkg::tMicroword uword;
  cramPkg::tMicroword wrData;
  cramPkg::tCradr     wrAdr;
  cramPkg::tCradr     dispBits;
  cramPkg::tCradr     diagAdr;
  cramPkg::tDispOp    disp;
  logic [2:0]         condSel;
  logic               wrEn;
  logic               run;
  logic               step;
  logic               clearPc;
  logic               clearErr;

  stackPort stkIf ();

  // Microword field goes out to the machine
  assign field = uword.field;

  diagPort u_diagPort (
    .clk(clk), .RESET(RESET), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datW(datW), .datR(datR), .ack(ack), .running(running), .cradr(cradr),
    .sp(stkIf.sp), .stackErr(stkIf.err), .wrEn(wrEn), .wrAdr(wrAdr),
    .wrData(wrData), .run(run), .step(step), .clearPc(clearPc),
    .clearErr(clearErr), .diagAdr(diagAdr)
  );

  seqControl u_seqControl (
    .clk(clk), .RESET(RESET), .run(run), .step(step), .clearPc(clearPc),
    .uword(uword), .dispBits(dispBits), .stk(stkIf.ctrl), .cradr(cradr),
    .running(running), .disp(disp), .condSel(condSel)
  );

  dispatchSelect u_dispatchSelect (
    .disp(disp), .condSel(condSel), .cond(cond), .drj(drj),
    .diagAdr(diagAdr), .retAdr(stkIf.retAdr), .dispBits(dispBits)
  );

  returnStack u_returnStack (
    .clk(clk), .RESET(RESET), .clearErr(clearErr), .stk(stkIf.stack)
  );

  controlStore u_controlStore (
    .clk(clk), .wrEn(wrEn), .wrAdr(wrAdr), .wrData(wrData),
    .rdAdr(cradr), .uword(uword)
  );

endmodule

//--- test/cramSeq_checker.sv
// Concurrent assertions on the diagnostic handshake and the stack requests, bound into the top level
`timescale 1ns/1ps

module cramSeq_checker (
  input logic           clk,
  input logic           RESET,
  input logic           stb,
  input logic           ack,
  input logic           push,
  input logic           pop,
  input cramPkg::tCradr cradr,
  input logic           running,
  input logic           step,
  input logic           clearPc
);

  // Count of failed assertions
  int failCount = 0;

  // Single-cycle ack
  ackOneCycle: assert property (@(posedge clk) disable iff (RESET) ack |=> !ack)
    else begin
      failCount = failCount + 1;
      $error("ack held for more than one cycle");
    end

  ackWithStb: assert property (@(posedge clk) disable iff (RESET) ack |-> stb)
    else begin
      failCount = failCount + 1;
      $error("ack without stb");
    end

  pushPopExclusive: assert property (@(posedge clk) disable iff (RESET) !(push && pop))
    else begin
      failCount = failCount + 1;
      $error("push and pop high together");
    end

  // Halted with no request, address must hold
  haltedAdrStable: assert property (@(posedge clk) disable iff (RESET)
      (!running && !step && !clearPc) |=> $stable(cradr))
    else begin
      failCount = failCount + 1;
      $error("address moved while halted");
    end

endmodule

//--- test/cramSeq_tb.sv
// Testbench for the sequencer: loads a microprogram over Wishbone, then runs a scenario table
`timescale 1ns/1ps
`include "cramSeq_macros.svh"

module cramSeq_tb;

  // Start action of a scenario row
  typedef enum logic [2:0] {ACT_GOTO, ACT_CONT, ACT_CLRERR, ACT_RUN, ACT_RUNERR} tAction;

  // Expected values hold after the start action and the single steps
  typedef struct packed {
    tAction           act;
    cramPkg::tCradr   start;
    logic [7:0]       cond;
    logic [3:0]       drj;
    logic [3:0]       steps;
    cramPkg::tCradr   expAdr;
    logic [`SP_W-1:0] expSp;
    logic             expErr;
    logic [7:0]       expField;
  } tRow;

  localparam int ProgLen       = 22;
  localparam int NumRows       = 23;
  localparam int MaxSteps      = 7;
  localparam int TimeoutCycles = (ProgLen + NumRows * (MaxSteps + 10)) * 10;

  logic              clk;
  logic              RESET;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [2:0]        adr;
  logic [`WB_DW-1:0] datW;
  logic [`WB_DW-1:0] datR;
  logic              ack;
  logic [7:0]        cond;
  logic [3:0]        drj;
  cramPkg::tCradr    cradr;
  logic [7:0]        field;
  logic              running;
  tRow               rows [NumRows];
  int                cycles = 0;

  cramSeq u_cramSeq (
    .clk(clk), .RESET(RESET), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datW(datW), .datR(datR), .ack(ack), .cond(cond), .drj(drj),
    .cradr(cradr), .field(field), .running(running)
  );

  bind cramSeq cramSeq_checker u_checker (
    .clk(clk), .RESET(RESET), .stb(stb), .ack(ack), .push(stkIf.push),
    .pop(stkIf.pop), .cradr(cradr), .running(running), .step(step),
    .clearPc(clearPc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit scaled to the program load and the table
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the bus or the sequencer stopped responding", cycles);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end else if (u_cramSeq.u_checker.failCount != 0) begin
      $display("A bound assertion failed before %0t", $time);
      $display("Test FAILED");
      $fatal(1, "assertion failure");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus and sequencer tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("Test FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic waitAck();
    @(negedge clk);
    while (ack !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic writeReg(input logic [2:0] a, input logic [`WB_DW-1:0] d);
    @(posedge clk);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= 1'b1;
    adr  <= a;
    datW <= d;
    waitAck();
    // Master drops the strobe once ack is seen
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic readReg(input logic [2:0] a, output logic [`WB_DW-1:0] d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    waitAck();
    d = datR;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic waitRunning(input logic level);
    @(negedge clk);
    while (running !== level) begin
      @(negedge clk);
    end
  endtask

  function automatic cramPkg::tMicroword makeWord(input cramPkg::tCradr j,
      input cramPkg::tDispOp disp, input logic call, input logic [2:0] condSel,
      input logic halt, input logic [7:0] fld);
    cramPkg::tMicroword w;
    w.j       = j;
    w.disp    = disp;
    w.call    = call;
    w.condSel = condSel;
    w.halt    = halt;
    w.field   = fld;
    return w;
  endfunction

  task automatic loadWord(input cramPkg::tCradr a, input cramPkg::tMicroword w);
    writeReg(`REG_CADR, `WB_DW'(a));
    writeReg(`REG_CDATA, `WB_DW'(w));
  endtask

  // Step request, then wait for the halt that follows one word
  task automatic stepOnce();
    writeReg(`REG_CTRL, 32'h2);
    waitRunning(1'b0);
  endtask

  // Word 0 dispatches through the diagnostic address
  task automatic gotoAddress(input cramPkg::tCradr a);
    writeReg(`REG_DIAG, `WB_DW'(a));
    writeReg(`REG_CTRL, 32'h4);
    stepOnce();
  endtask

  task automatic runToHalt(input cramPkg::tCradr a, input logic [7:0] exitCond);
    writeReg(`REG_DIAG, `WB_DW'(a));
    writeReg(`REG_CTRL, 32'h4);
    writeReg(`REG_CTRL, 32'h1);
    waitRunning(1'b1);
    // Store write while running must leave 0xF0 as loaded
    writeReg(`REG_CADR, 32'hF0);
    writeReg(`REG_CDATA, `WB_DW'(makeWord(8'hF0, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'hA5)));
    @(posedge clk);
    cond <= exitCond;
    waitRunning(1'b0);
    writeReg(`REG_CTRL, 32'h0);
  endtask

  // Free run until the sequencer stops on its own, then drop run
  task automatic runUntilStop(input cramPkg::tCradr a);
    writeReg(`REG_DIAG, `WB_DW'(a));
    writeReg(`REG_CTRL, 32'h4);
    writeReg(`REG_CTRL, 32'h1);
    waitRunning(1'b0);
    writeReg(`REG_CTRL, 32'h0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic checkCradr(input cramPkg::tCradr got, input cramPkg::tCradr exp, input int row);
    if (got !== exp) begin
      $display("Fail %0t: row %0d cradr %h, expected %h", $time, row, got, exp);
      abortRun();
    end
  endtask

  task automatic checkStatus(input cramPkg::tStatus got, input cramPkg::tStatus exp,
      input int row);
    if (got !== exp) begin
      $display("Fail %0t: row %0d status adr %h sp %0d run %b err %b, expected %h %0d %b %b",
        $time, row, got.cradr, got.sp, got.running, got.stackErr,
        exp.cradr, exp.sp, exp.running, exp.stackErr);
      abortRun();
    end
  endtask

  task automatic checkField(input logic [7:0] got, input logic [7:0] exp, input int row);
    if (got !== exp) begin
      $display("Fail %0t: row %0d field %h, expected %h", $time, row, got, exp);
      abortRun();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Microprogram and scenario table
  //////////////////////////////////////////////////////////////////////

  task automatic loadProgram();
    loadWord(8'h00, makeWord(8'h00, cramPkg::DISP_DIAG, 1'b0, 3'd0, 1'b0, 8'h00));
    // Plain jump chain 10, 20, 35, back to 10
    loadWord(8'h10, makeWord(8'h20, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h10));
    loadWord(8'h20, makeWord(8'h35, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h20));
    loadWord(8'h35, makeWord(8'h10, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h35));
    // J of 63 tells OR from add
    loadWord(8'h50, makeWord(8'h63, cramPkg::DISP_DRJ, 1'b0, 3'd0, 1'b0, 8'h50));
    loadWord(8'h67, makeWord(8'h67, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h67));
    loadWord(8'h6B, makeWord(8'h6B, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h6B));
    loadWord(8'h70, makeWord(8'h7A, cramPkg::DISP_SKIP, 1'b0, 3'd5, 1'b0, 8'h70));
    loadWord(8'h7A, makeWord(8'h7A, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h7A));
    loadWord(8'h7B, makeWord(8'h7B, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h7B));
    // Three nested calls and their returns
    loadWord(8'h80, makeWord(8'h90, cramPkg::DISP_NONE, 1'b1, 3'd0, 1'b0, 8'h80));
    loadWord(8'h90, makeWord(8'hA0, cramPkg::DISP_NONE, 1'b1, 3'd0, 1'b0, 8'h90));
    loadWord(8'hA0, makeWord(8'hB0, cramPkg::DISP_NONE, 1'b1, 3'd0, 1'b0, 8'hA0));
    loadWord(8'hB0, makeWord(8'h00, cramPkg::DISP_RET, 1'b0, 3'd0, 1'b0, 8'hB0));
    loadWord(8'hA1, makeWord(8'h00, cramPkg::DISP_RET, 1'b0, 3'd0, 1'b0, 8'hA1));
    loadWord(8'h91, makeWord(8'h00, cramPkg::DISP_RET, 1'b0, 3'd0, 1'b0, 8'h91));
    loadWord(8'h81, makeWord(8'h81, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h81));
    // Self call fills the stack
    loadWord(8'hC0, makeWord(8'hC0, cramPkg::DISP_NONE, 1'b1, 3'd0, 1'b0, 8'hC0));
    loadWord(8'hC1, makeWord(8'hC1, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'hC1));
    // Loop on cond[2] low, then the halt word jumps to 10 as it stops
    loadWord(8'h40, makeWord(8'h40, cramPkg::DISP_SKIP, 1'b0, 3'd2, 1'b0, 8'h40));
    loadWord(8'h41, makeWord(8'h10, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b1, 8'h41));
    loadWord(8'hF0, makeWord(8'hF0, cramPkg::DISP_NONE, 1'b0, 3'd0, 1'b0, 8'h5A));
  endtask

  // act, start, cond, drj, steps, expected adr, sp, err, field
  task automatic buildTable();
    rows[0]  = '{ACT_GOTO,   8'h10, 8'h00, 4'h0, 4'd0, 8'h10, 3'd0, 1'b0, 8'h10};
    rows[1]  = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'h20, 3'd0, 1'b0, 8'h20};
    rows[2]  = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'h35, 3'd0, 1'b0, 8'h35};
    rows[3]  = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'h10, 3'd0, 1'b0, 8'h10};
    rows[4]  = '{ACT_GOTO,   8'h50, 8'h00, 4'h5, 4'd1, 8'h67, 3'd0, 1'b0, 8'h67};
    rows[5]  = '{ACT_GOTO,   8'h50, 8'h00, 4'hA, 4'd1, 8'h6B, 3'd0, 1'b0, 8'h6B};
    rows[6]  = '{ACT_GOTO,   8'h70, 8'h20, 4'h0, 4'd1, 8'h7B, 3'd0, 1'b0, 8'h7B};
    rows[7]  = '{ACT_GOTO,   8'h70, 8'hDF, 4'hF, 4'd1, 8'h7A, 3'd0, 1'b0, 8'h7A};
    rows[8]  = '{ACT_GOTO,   8'h80, 8'h00, 4'h0, 4'd1, 8'h90, 3'd1, 1'b0, 8'h90};
    rows[9]  = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'hA0, 3'd2, 1'b0, 8'hA0};
    rows[10] = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'hB0, 3'd3, 1'b0, 8'hB0};
    rows[11] = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'hA1, 3'd2, 1'b0, 8'hA1};
    rows[12] = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'h91, 3'd1, 1'b0, 8'h91};
    rows[13] = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'h81, 3'd0, 1'b0, 8'h81};
    // Empty return, then clear
    rows[14] = '{ACT_GOTO,   8'hB0, 8'h00, 4'h0, 4'd1, 8'hB0, 3'd0, 1'b1, 8'hB0};
    rows[15] = '{ACT_CLRERR, 8'h00, 8'h00, 4'h0, 4'd0, 8'hB0, 3'd0, 1'b0, 8'hB0};
    // Eight calls wrap sp to 0, the ninth overflows while running
    rows[16] = '{ACT_GOTO,   8'hC0, 8'h00, 4'h0, 4'd7, 8'hC0, 3'd7, 1'b0, 8'hC0};
    rows[17] = '{ACT_CONT,   8'h00, 8'h00, 4'h0, 4'd1, 8'hC0, 3'd0, 1'b0, 8'hC0};
    rows[18] = '{ACT_RUNERR, 8'hC0, 8'h00, 4'h0, 4'd0, 8'hC0, 3'd0, 1'b1, 8'hC0};
    rows[19] = '{ACT_CLRERR, 8'h00, 8'h00, 4'h0, 4'd0, 8'hC0, 3'd0, 1'b0, 8'hC0};
    rows[20] = '{ACT_GOTO,   8'hB0, 8'h00, 4'h0, 4'd1, 8'hC1, 3'd7, 1'b0, 8'hC1};
    rows[21] = '{ACT_RUN,    8'h40, 8'h04, 4'h0, 4'd0, 8'h10, 3'd7, 1'b0, 8'h10};
    rows[22] = '{ACT_GOTO,   8'hF0, 8'h00, 4'h0, 4'd0, 8'hF0, 3'd7, 1'b0, 8'h5A};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    tRow               r;
    cramPkg::tStatus   expStat;
    logic [`WB_DW-1:0] rd;
    int                i;
    RESET <= 1'b1;
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= 3'd0;
    datW  <= '0;
    cond  <= 8'h00;
    drj   <= 4'h0;
    repeat (5) @(posedge clk);
    RESET <= 1'b0;
    buildTable();
    loadProgram();
    for (i = 0; i < NumRows; i++) begin
      r = rows[i];
      @(posedge clk);
      // Run rows keep cond low until the store write is done
      cond <= (r.act == ACT_RUN) ? 8'h00 : r.cond;
      drj  <= r.drj;
      case (r.act)
        ACT_GOTO:   gotoAddress(r.start);
        ACT_CLRERR: writeReg(`REG_CTRL, 32'h8);
        ACT_RUN:    runToHalt(r.start, r.cond);
        ACT_RUNERR: runUntilStop(r.start);
        default: begin
        end
      endcase
      repeat (r.steps) stepOnce();
      readReg(`REG_STAT, rd);
      // Outputs are sampled away from the active edge
      @(negedge clk);
      expStat.cradr    = r.expAdr;
      expStat.sp       = r.expSp;
      expStat.running  = 1'b0;
      expStat.stackErr = r.expErr;
      checkStatus(cramPkg::tStatus'(rd[$bits(cramPkg::tStatus)-1:0]), expStat, i);
      checkCradr(cradr, r.expAdr, i);
      checkField(field, r.expField, i);
    end
    if (u_cramSeq.u_checker.failCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", u_cramSeq.u_checker.failCount);
      $display("Test FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- cramSeq.f
+incdir+hw
hw/cramPkg.sv
hw/stackPort.sv
hw/controlStore.sv
hw/dispatchSelect.sv
hw/returnStack.sv
hw/seqControl.sv
hw/diagPort.sv
hw/cramSeq.sv
test/cramSeq_checker.sv
test/cramSeq_tb.sv

//--- Makefile
# Verilator build and run of the sequencer testbench

VERILATOR ?= verilator
TOP       ?= cramSeq_tb
RTL_TOP   ?= cramSeq
FILELIST  ?= cramSeq.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line is in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
